// ==== stream_link.f ====
source/stream_link_pkg.sv
source/data_ff.sv
source/credit_tx.sv
source/credit_rx.sv
source/link_ctrl.sv
source/stream_link.sv
bench/stream_link_asserts.sv
bench/tb_stream_link.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_stream_link
RTL_TOP    ?= stream_link
FILELIST   ?= stream_link.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Test failed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= source/stream_link_pkg.sv source/data_ff.sv source/credit_tx.sv \
              source/credit_rx.sv source/link_ctrl.sv source/stream_link.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_stream_link.sv ====
`timescale 1ns/1ps

module tb_stream_link
    import stream_link_pkg::*;
    ();

    localparam int RANDOM_WORDS   = 2000;
    localparam int STALL_WORDS    = 20;
    localparam int ENABLE_WORDS   = 100;
    localparam int CLEAR_WORDS    = 300;
    localparam int TOTAL_WORDS    = RANDOM_WORDS + STALL_WORDS + ENABLE_WORDS + CLEAR_WORDS;
    localparam int TIMEOUT_CYCLES = 10 * TOTAL_WORDS + 1000;
    localparam int MAX_IN_FLIGHT  = LINK_CREDITS + 4;   // both slices plus the queue.

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    data_t      s_data = '0;
    logic       s_valid = 1'b0;
    logic       s_ready;
    data_t      m_data;
    logic       m_valid;
    logic       m_ready = 1'b0;
    link_cmd_t  cmd = CMD_NOP;
    logic       cmd_valid = 1'b0;
    count_t     count;

    int unsigned send_idx = 0;      // words accepted at s.
    int unsigned recv_idx = 0;      // words delivered at m.
    int unsigned send_limit = 0;
    int unsigned valid_pct = 0;
    int unsigned ready_pct = 0;
    int unsigned cycles = 0;
    int unsigned held = 0;
    logic        stall = 1'b0;
    logic        out_taken;
    count_t      tally = '0;        // deliveries since the last clear.
    int          data_errors = 0;
    int          count_errors = 0;
    int          flag_errors = 0;
    int          assert_errors = 0;
    int          other_errors = 0;

    stream_link i_stream_link (
        .clk        (clk),
        .reset      (reset),
        .s_data     (s_data),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .m_data     (m_data),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .count      (count)
    );

    always #5 clk = ~clk;

    function automatic data_t expected_word(input int unsigned n);
        return data_t'(n % (2 ** DATA_BITS));
    endfunction

    task automatic check_data(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            data_errors++;
            $display("Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_count(input string name, input count_t actual, input count_t expected);
        if (actual !== expected) begin
            count_errors++;
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            flag_errors++;
            $display("Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic send_command(input link_cmd_t c);
        @(posedge clk);
        cmd       <= c;
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd       <= CMD_NOP;
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_delivered(input int unsigned target);
        while (recv_idx < target) begin
            @(negedge clk);
        end
    endtask

    // source holds a word until it is taken, sink ready is free.
    always @(posedge clk) begin
        if (!reset) begin
            if (s_valid && s_ready) begin
                send_idx = send_idx + 1;
            end
            if (!s_valid || s_ready) begin
                s_valid <= (send_idx < send_limit) && ($urandom_range(99) < valid_pct);
                s_data  <= data_t'(send_idx);
            end
            m_ready <= !stall && ($urandom_range(99) < ready_pct);
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            check_count("count", count, tally);
            out_taken = m_valid && m_ready;
            if (out_taken) begin
                check_data("m_data", m_data, expected_word(recv_idx));
                recv_idx = recv_idx + 1;
            end
            if (cmd_valid && cmd == CMD_CLEAR_COUNT) begin
                tally = out_taken ? count_t'(1) : count_t'(0);
            end else if (out_taken) begin
                tally = tally + count_t'(1);
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && send_idx - recv_idx > MAX_IN_FLIGHT) begin
            other_errors++;
            $display("more than %0d words held inside the link at %0t", MAX_IN_FLIGHT, $time);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d words delivered", cycles, recv_idx);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h6ca9_52e0));
        repeat (9) begin
            @(negedge clk);
            check_flag("m_valid", m_valid, 1'b0);
            check_flag("s_ready", s_ready, 1'b0);
            check_count("count", count, '0);
        end
        @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        valid_pct  = 70;
        ready_pct  = 70;
        send_limit = RANDOM_WORDS;
        wait_delivered(send_limit);

        // sink stalls, the link fills up and pushes back.
        valid_pct  = 100;
        stall      = 1'b1;
        send_limit = send_idx + STALL_WORDS;
        repeat (50) @(negedge clk);
        check_flag("s_ready", s_ready, 1'b0);
        stall     = 1'b0;
        ready_pct = 100;
        wait_delivered(send_limit);

        send_limit = send_idx + ENABLE_WORDS;
        repeat (20) @(negedge clk);
        send_command(CMD_DISABLE);
        repeat (2) @(posedge clk);
        @(negedge clk);
        held = send_idx;
        repeat (30) @(negedge clk);
        if (send_idx != held) begin
            other_errors++;
            $display("words still accepted %0d cycles after the link was disabled", 32);
        end
        if (send_idx - recv_idx > 2) begin
            other_errors++;
            $display("words already on the link did not drain while disabled");
        end
        send_command(CMD_ENABLE);
        wait_delivered(send_limit);

        @(negedge clk);
        valid_pct  = 70;
        ready_pct  = 70;
        send_limit = send_idx + CLEAR_WORDS;
        wait_delivered(recv_idx + 100);
        send_command(CMD_CLEAR_COUNT);
        wait_delivered(send_limit);
        @(negedge clk);
        check_count("count", count, tally);

        assert_errors = i_stream_link.i_stream_link_asserts.failures;
        $display("errors: data %0d, count %0d, flag %0d, assert %0d, other %0d",
                 data_errors, count_errors, flag_errors, assert_errors, other_errors);
        if (data_errors + count_errors + flag_errors + assert_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== bench/stream_link_asserts.sv ====
`timescale 1ns/1ps

module stream_link_asserts
    import stream_link_pkg::*;
    (
        input logic                     clk,
        input logic                     reset,
        input data_t                    s_data,
        input logic                     s_valid,
        input logic                     s_ready,
        input data_t                    tx_data,
        input logic                     tx_valid,
        input logic                     tx_ready,
        input data_t                    m_data,
        input logic                     m_valid,
        input logic                     m_ready,
        input logic [CREDIT_BITS-1:0]   credits,
        input logic                     flit_valid,
        input logic [CREDIT_BITS-1:0]   fill
    );

    int failures = 0;       // assertion failures so far.

    s_hold: assert property (@(posedge clk) disable iff (reset)
        s_valid && !s_ready |=> s_valid && $stable(s_data))
        else begin
            failures++;
            $error("upstream word dropped or changed while stalled");
        end

    tx_hold: assert property (@(posedge clk) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
        else begin
            failures++;
            $error("input slice word dropped or changed while stalled");
        end

    m_hold: assert property (@(posedge clk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_data))
        else begin
            failures++;
            $error("downstream word dropped or changed while stalled");
        end

    credit_max: assert property (@(posedge clk) disable iff (reset)
        credits <= CREDIT_BITS'(LINK_CREDITS))
        else begin
            failures++;
            $error("credit counter above the receiver depth");
        end

    // every credit is either held, on the link, or a queued word.
    credit_send: assert property (@(posedge clk) disable iff (reset)
        int'(credits) + int'(flit_valid) + int'(fill) == LINK_CREDITS)
        else begin
            failures++;
            $error("flit sent with no credit left");
        end

endmodule

bind stream_link stream_link_asserts i_stream_link_asserts (
    .clk        (clk),
    .reset      (reset),
    .s_data     (s_data),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .m_data     (m_data),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .credits    (i_credit_tx.credits),
    .flit_valid (link_flit.valid),
    .fill       (i_credit_rx.fill)
);

// ==== source/stream_link.sv ====
`timescale 1ns / 1ps
`default_nettype none


module stream_link
    import stream_link_pkg::*;
        (
            input   var logic       reset,
            input   var logic       clk,

            input   var data_t      s_data,
            input   var logic       s_valid,
            output  var logic       s_ready,

            output  var data_t      m_data,
            output  var logic       m_valid,
            input   var logic       m_ready,

            input   var link_cmd_t  cmd,
            input   var logic       cmd_valid,
            output  var count_t     count
        );

    data_t          tx_data;
    logic           tx_valid;
    logic           tx_ready;

    link_flit_t     link_flit;
    logic           credit_return;

    data_t          rx_data;
    logic           rx_valid;
    logic           rx_ready;

    logic           link_enable;
    logic           delivered;

    assign delivered = m_valid && m_ready;

    data_ff
            #(
                .S_REGS         (1'b1           ),
                .M_REGS         (1'b1           )
            )
        i_in_ff
            (
                .reset          (reset          ),
                .clk            (clk            ),
                .s_data         (s_data         ),
                .s_valid        (s_valid        ),
                .s_ready        (s_ready        ),
                .m_data         (tx_data        ),
                .m_valid        (tx_valid       ),
                .m_ready        (tx_ready       )
            );

    credit_tx
        i_credit_tx
            (
                .reset          (reset          ),
                .clk            (clk            ),
                .s_data         (tx_data        ),
                .s_valid        (tx_valid       ),
                .s_ready        (tx_ready       ),
                .link_enable    (link_enable    ),
                .credit_return  (credit_return  ),
                .link_flit      (link_flit      )
            );

    credit_rx
        i_credit_rx
            (
                .reset          (reset          ),
                .clk            (clk            ),
                .link_flit      (link_flit      ),
                .credit_return  (credit_return  ),
                .m_data         (rx_data        ),
                .m_valid        (rx_valid       ),
                .m_ready        (rx_ready       )
            );

    data_ff
            #(
                .S_REGS         (1'b1           ),
                .M_REGS         (1'b1           )
            )
        i_out_ff
            (
                .reset          (reset          ),
                .clk            (clk            ),
                .s_data         (rx_data        ),
                .s_valid        (rx_valid       ),
                .s_ready        (rx_ready       ),
                .m_data         (m_data         ),
                .m_valid        (m_valid        ),
                .m_ready        (m_ready        )
            );

    link_ctrl
        i_link_ctrl
            (
                .reset          (reset          ),
                .clk            (clk            ),
                .cmd            (cmd            ),
                .cmd_valid      (cmd_valid      ),
                .delivered      (delivered      ),
                .link_enable    (link_enable    ),
                .count          (count          )
            );

endmodule


`default_nettype wire

// ==== source/link_ctrl.sv ====
`timescale 1ns / 1ps
`default_nettype none


module link_ctrl
    import stream_link_pkg::*;
        (
            input   var logic       reset,
            input   var logic       clk,

            input   var link_cmd_t  cmd,
            input   var logic       cmd_valid,

            input   var logic       delivered,

            output  var logic       link_enable,
            output  var count_t     count
        );

    logic   enable_next;
    logic   clear;

    always_comb begin
        enable_next = link_enable;
        clear       = 1'b0;
        if ( cmd_valid ) begin
            case ( cmd )
                CMD_ENABLE:         enable_next = 1'b1;
                CMD_DISABLE:        enable_next = 1'b0;
                CMD_CLEAR_COUNT:    clear       = 1'b1;
                default:            ;                       // nop.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ( reset ) begin
            link_enable <= 1'b1;
            count       <= '0;
        end
        else begin
            link_enable <= enable_next;
            if ( clear ) begin
                count <= count_t'(delivered);   // a word delivered with the clear counts.
            end
            else if ( delivered ) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule


`default_nettype wire

// ==== source/credit_rx.sv ====
`timescale 1ns / 1ps
`default_nettype none


module credit_rx
    import stream_link_pkg::*;
        (
            input   var logic       reset,
            input   var logic       clk,

            input   var link_flit_t link_flit,
            output  var logic       credit_return,

            output  var data_t      m_data,
            output  var logic       m_valid,
            input   var logic       m_ready
        );

    data_t                      mem     [LINK_CREDITS];
    logic   [PTR_BITS-1:0]      wr_ptr;
    logic   [PTR_BITS-1:0]      rd_ptr;
    logic   [CREDIT_BITS-1:0]   fill;
    logic                       wr_en;
    logic                       rd_en;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if ( ptr == PTR_BITS'(LINK_CREDITS - 1) ) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr_en = link_flit.valid;         // credits guarantee a free slot.
    assign rd_en = m_valid && m_ready;

    always_ff @(posedge clk) begin
        if ( reset ) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else begin
            if ( wr_en ) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if ( rd_en ) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            fill <= fill + CREDIT_BITS'(wr_en) - CREDIT_BITS'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if ( wr_en ) begin
            mem[wr_ptr] <= link_flit.data;
        end
    end

    assign m_valid       = (fill != '0);
    assign m_data        = mem[rd_ptr];
    assign credit_return = rd_en;           // one credit back per word delivered.

endmodule


`default_nettype wire

// ==== source/credit_tx.sv ====
`timescale 1ns / 1ps
`default_nettype none


module credit_tx
    import stream_link_pkg::*;
        (
            input   var logic       reset,
            input   var logic       clk,

            input   var data_t      s_data,
            input   var logic       s_valid,
            output  var logic       s_ready,

            input   var logic       link_enable,
            input   var logic       credit_return,

            output  var link_flit_t link_flit
        );

    logic   [CREDIT_BITS-1:0]   credits;
    logic                       send;
    logic                       flit_valid;
    data_t                      flit_data;

    // a word is only taken when the receiver is sure to have room.
    assign s_ready = (credits != '0) && link_enable;
    assign send    = s_valid && s_ready;

    always_ff @(posedge clk) begin
        if ( reset ) begin
            credits    <= CREDIT_BITS'(LINK_CREDITS);
            flit_valid <= 1'b0;
        end
        else begin
            credits    <= credits + CREDIT_BITS'(credit_return) - CREDIT_BITS'(send);
            flit_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        if ( send ) begin
            flit_data <= s_data;
        end
    end

    assign link_flit.valid = flit_valid;
    assign link_flit.data  = flit_data;

endmodule


`default_nettype wire

// ==== source/data_ff.sv ====
`timescale 1ns / 1ps
`default_nettype none


module data_ff
    import stream_link_pkg::*;
        #(
            parameter   bit     S_REGS = 1'b1,
            parameter   bit     M_REGS = 1'b1
        )
        (
            input   var logic   reset,
            input   var logic   clk,

            input   var data_t  s_data,
            input   var logic   s_valid,
            output  var logic   s_ready,

            output  var data_t  m_data,
            output  var logic   m_valid,
            input   var logic   m_ready
        );

    data_t      mid_data;       // between the skid stage and the output stage.
    logic       mid_valid;
    logic       mid_ready;

    if ( S_REGS ) begin : g_s_regs
        data_t  skid_data;
        logic   skid_valid;
        logic   ready_reg;
        logic   skid_next;

        // the skid fills when a word is taken while the next stage stalls.
        always_comb begin
            skid_next = !mid_ready && (skid_valid || (s_valid && ready_reg));
        end

        always_ff @(posedge clk) begin
            if ( reset ) begin
                skid_valid <= 1'b0;
                ready_reg  <= 1'b0;
            end
            else begin
                skid_valid <= skid_next;
                ready_reg  <= !skid_next;
            end
        end

        always_ff @(posedge clk) begin
            if ( !skid_valid ) begin
                skid_data <= s_data;
            end
        end

        assign s_ready   = ready_reg;                               // registered ready.
        assign mid_data  = skid_valid ? skid_data : s_data;
        assign mid_valid = skid_valid || (s_valid && ready_reg);
    end
    else begin : g_s_bypass
        assign s_ready   = mid_ready;
        assign mid_data  = s_data;
        assign mid_valid = s_valid;
    end

    if ( M_REGS ) begin : g_m_regs
        data_t  out_data;
        logic   out_valid;

        assign mid_ready = !out_valid || m_ready;

        always_ff @(posedge clk) begin
            if ( reset ) begin
                out_valid <= 1'b0;
            end
            else if ( mid_ready ) begin
                out_valid <= mid_valid;
            end
        end

        always_ff @(posedge clk) begin
            if ( mid_valid && mid_ready ) begin
                out_data <= mid_data;
            end
        end

        assign m_data  = out_data;
        assign m_valid = out_valid;
    end
    else begin : g_m_bypass
        assign mid_ready = m_ready;
        assign m_data    = mid_data;
        assign m_valid   = mid_valid;
    end

endmodule


`default_nettype wire

// ==== source/stream_link_pkg.sv ====
package stream_link_pkg;

    localparam  int     DATA_BITS    = 16;
    localparam  int     LINK_CREDITS = 4;
    localparam  int     CREDIT_BITS  = 3;                       // holds 0 to LINK_CREDITS.
    localparam  int     COUNT_BITS   = 32;
    localparam  int     PTR_BITS     = $clog2(LINK_CREDITS);    // receiver queue index.

    typedef logic [DATA_BITS-1:0]   data_t;
    typedef logic [COUNT_BITS-1:0]  count_t;

    // one word on the link; valid alone marks a transfer.
    typedef struct packed {
        logic   valid;
        data_t  data;
    } link_flit_t;

    typedef enum logic [1:0] {
        CMD_NOP         = 2'd0,
        CMD_ENABLE      = 2'd1,
        CMD_DISABLE     = 2'd2,
        CMD_CLEAR_COUNT = 2'd3
    } link_cmd_t;

endpackage
